// File: hdl/dual_issue_pkg.sv
package dual_issue_pkg;

    // datapath widths
    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // instruction queue geometry
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_PTR_W = 3;
    localparam int FIFO_CNT_W = 4;

    // fetch
    localparam logic [DATA_W-1:0] RESET_PC = '0;
    localparam int INST_BYTES = 4;

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;

    // function field of SPECIAL
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI
    } alu_op_t;

endpackage

// File: hdl/fetch_pc_gen.sv
`timescale 1ns/10ps

module fetch_pc_gen (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              full,
    input  logic                              inst_data_ok,
    input  logic                              inst_data_ok1,
    input  logic                              inst_data_ok2,
    output logic                              inst_sram_en,
    output logic [dual_issue_pkg::DATA_W-1:0] fetch_pc,
    output logic                              push1,
    output logic                              push2
);
    import dual_issue_pkg::*;

    // request only while two queue slots are free
    assign inst_sram_en = ~full;

    // second word counts only behind the first
    assign push1 = inst_sram_en & inst_data_ok & inst_data_ok1;
    assign push2 = push1 & inst_data_ok2;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fetch_pc <= RESET_PC;
        end else if (push2) begin
            fetch_pc <= fetch_pc + DATA_W'(2 * INST_BYTES);
        end else if (push1) begin
            fetch_pc <= fetch_pc + DATA_W'(INST_BYTES);
        end
    end

endmodule

// File: hdl/inst_fifo.sv
`timescale 1ns/10ps

module inst_fifo (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              push1,
    input  logic                              push2,
    input  logic [dual_issue_pkg::DATA_W-1:0] wdata1,
    input  logic [dual_issue_pkg::DATA_W-1:0] wdata2,
    input  logic                              pop1,
    input  logic                              pop2,
    output logic [dual_issue_pkg::DATA_W-1:0] head_inst,
    output logic [dual_issue_pkg::DATA_W-1:0] next_inst,
    output logic                              empty,
    output logic                              almost_empty,
    output logic                              full
);
    import dual_issue_pkg::*;

    logic [DATA_W-1:0]     mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_PTR_W-1:0] wr_ptr_nxt;
    logic [FIFO_PTR_W-1:0] rd_ptr_nxt;
    logic [FIFO_CNT_W-1:0] count;

    // pointers wrap on their own at a power-of-two depth
    assign wr_ptr_nxt = wr_ptr + FIFO_PTR_W'(1);
    assign rd_ptr_nxt = rd_ptr + FIFO_PTR_W'(1);

    assign head_inst    = mem[rd_ptr];
    assign next_inst    = mem[rd_ptr_nxt];
    assign empty        = (count == '0);
    assign almost_empty = (count == FIFO_CNT_W'(1));
    // room for a full pair is required before a fetch
    assign full         = (count > FIFO_CNT_W'(FIFO_DEPTH - 2));

    always_ff @(posedge clk) begin
        if (push1) begin
            mem[wr_ptr] <= wdata1;
        end
        if (push2) begin
            mem[wr_ptr_nxt] <= wdata2;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + FIFO_PTR_W'(push1) + FIFO_PTR_W'(push2);
            rd_ptr <= rd_ptr + FIFO_PTR_W'(pop1) + FIFO_PTR_W'(pop2);
            // net change of both ports together
            count  <= count + FIFO_CNT_W'(push1) + FIFO_CNT_W'(push2)
                            - FIFO_CNT_W'(pop1) - FIFO_CNT_W'(pop2);
        end
    end

endmodule

// File: hdl/inst_decoder.sv
`timescale 1ns/10ps

module inst_decoder (
    input  logic [dual_issue_pkg::DATA_W-1:0]     inst,
    output logic [dual_issue_pkg::REG_ADDR_W-1:0] rs,
    output logic [dual_issue_pkg::REG_ADDR_W-1:0] rt,
    output dual_issue_pkg::alu_op_t               aluop,
    output logic                                  alu_sela,
    output logic                                  alu_selb,
    output logic [4:0]                            shamt,
    output logic [dual_issue_pkg::DATA_W-1:0]     imm_value,
    output logic                                  reg_wen,
    output logic [dual_issue_pkg::REG_ADDR_W-1:0] reg_waddr
);
    import dual_issue_pkg::*;

    logic [5:0]            op;
    logic [5:0]            funct;
    logic [REG_ADDR_W-1:0] rd;
    logic                  known;

    assign op    = inst[31:26];
    assign rs    = inst[25:21];
    assign rt    = inst[20:16];
    assign rd    = inst[15:11];
    assign shamt = inst[10:6];
    assign funct = inst[5:0];

    // ORI takes a zero-extended immediate, the rest sign-extend
    assign imm_value = (op == OP_ORI) ? {16'h0000, inst[15:0]}
                                      : {{16{inst[15]}}, inst[15:0]};

    always_comb begin
        aluop     = ALU_ADD;
        alu_sela  = 1'b0;
        alu_selb  = 1'b1;
        reg_waddr = rt;
        known     = 1'b1;
        case (op)
            OP_SPECIAL: begin
                alu_selb  = 1'b0;
                reg_waddr = rd;
                case (funct)
                    FN_ADDU: aluop = ALU_ADD;
                    FN_SUBU: aluop = ALU_SUB;
                    FN_AND:  aluop = ALU_AND;
                    FN_OR:   aluop = ALU_OR;
                    FN_XOR:  aluop = ALU_XOR;
                    FN_SLT:  aluop = ALU_SLT;
                    FN_SLL: begin
                        aluop    = ALU_SLL;
                        alu_sela = 1'b1;
                    end
                    FN_SRL: begin
                        aluop    = ALU_SRL;
                        alu_sela = 1'b1;
                    end
                    default: known = 1'b0;
                endcase
            end
            OP_ADDIU: aluop = ALU_ADD;
            OP_ORI:   aluop = ALU_OR;
            OP_LUI:   aluop = ALU_LUI;
            default:  known = 1'b0;
        endcase
    end

    // unknown encodings and writes to r0 retire as no-ops
    assign reg_wen = known & (reg_waddr != '0);

endmodule

// File: hdl/regfile.sv
`timescale 1ns/10ps

module regfile (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic [dual_issue_pkg::REG_ADDR_W-1:0] ra1_a,
    input  logic [dual_issue_pkg::REG_ADDR_W-1:0] ra1_b,
    input  logic [dual_issue_pkg::REG_ADDR_W-1:0] ra2_a,
    input  logic [dual_issue_pkg::REG_ADDR_W-1:0] ra2_b,
    output logic [dual_issue_pkg::DATA_W-1:0]     rd1_a,
    output logic [dual_issue_pkg::DATA_W-1:0]     rd1_b,
    output logic [dual_issue_pkg::DATA_W-1:0]     rd2_a,
    output logic [dual_issue_pkg::DATA_W-1:0]     rd2_b,
    input  logic                                  wen1,
    input  logic                                  wen2,
    input  logic [dual_issue_pkg::REG_ADDR_W-1:0] wa1,
    input  logic [dual_issue_pkg::REG_ADDR_W-1:0] wa2,
    input  logic [dual_issue_pkg::DATA_W-1:0]     wd1,
    input  logic [dual_issue_pkg::DATA_W-1:0]     wd2
);
    import dual_issue_pkg::*;

    logic [DATA_W-1:0] regs [NUM_REGS];

    assign rd1_a = (ra1_a == '0) ? '0 : regs[ra1_a];
    assign rd1_b = (ra1_b == '0) ? '0 : regs[ra1_b];
    assign rd2_a = (ra2_a == '0) ? '0 : regs[ra2_a];
    assign rd2_b = (ra2_b == '0) ? '0 : regs[ra2_b];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wen1) begin
                regs[wa1] <= wd1;
            end
            // slave is younger, so its write lands last
            if (wen2) begin
                regs[wa2] <= wd2;
            end
        end
    end

endmodule

// File: hdl/issue_ctrl.sv
`timescale 1ns/10ps

module issue_ctrl (
    input  logic                                  empty,
    input  logic                                  almost_empty,
    input  logic                                  master_reg_wen,
    input  logic [dual_issue_pkg::REG_ADDR_W-1:0] master_reg_waddr,
    input  logic [dual_issue_pkg::REG_ADDR_W-1:0] slave_rs,
    input  logic [dual_issue_pkg::REG_ADDR_W-1:0] slave_rt,
    output logic                                  master_issue,
    output logic                                  slave_issue
);
    import dual_issue_pkg::*;

    logic raw_hazard;

    // slave reads what the master of the same pair writes
    assign raw_hazard = master_reg_wen &
                        ((master_reg_waddr == slave_rs) | (master_reg_waddr == slave_rt));

    assign master_issue = ~empty;
    // pair needs a second entry and no dependency inside the pair
    assign slave_issue  = master_issue & ~almost_empty & ~raw_hazard;

endmodule

// File: hdl/forward_unit.sv
`timescale 1ns/10ps

module forward_unit (
    input  logic [dual_issue_pkg::REG_ADDR_W-1:0] master_rs,
    input  logic [dual_issue_pkg::REG_ADDR_W-1:0] master_rt,
    input  logic [dual_issue_pkg::REG_ADDR_W-1:0] slave_rs,
    input  logic [dual_issue_pkg::REG_ADDR_W-1:0] slave_rt,
    input  logic [dual_issue_pkg::DATA_W-1:0]     master_rs_rf,
    input  logic [dual_issue_pkg::DATA_W-1:0]     master_rt_rf,
    input  logic [dual_issue_pkg::DATA_W-1:0]     slave_rs_rf,
    input  logic [dual_issue_pkg::DATA_W-1:0]     slave_rt_rf,
    input  logic                                  e_master_wen,
    input  logic [dual_issue_pkg::REG_ADDR_W-1:0] e_master_addr,
    input  logic [dual_issue_pkg::DATA_W-1:0]     e_master_data,
    input  logic                                  e_slave_wen,
    input  logic [dual_issue_pkg::REG_ADDR_W-1:0] e_slave_addr,
    input  logic [dual_issue_pkg::DATA_W-1:0]     e_slave_data,
    input  logic                                  wb_master_wen,
    input  logic [dual_issue_pkg::REG_ADDR_W-1:0] wb_master_addr,
    input  logic [dual_issue_pkg::DATA_W-1:0]     wb_master_data,
    input  logic                                  wb_slave_wen,
    input  logic [dual_issue_pkg::REG_ADDR_W-1:0] wb_slave_addr,
    input  logic [dual_issue_pkg::DATA_W-1:0]     wb_slave_data,
    output logic [dual_issue_pkg::DATA_W-1:0]     master_rs_value,
    output logic [dual_issue_pkg::DATA_W-1:0]     master_rt_value,
    output logic [dual_issue_pkg::DATA_W-1:0]     slave_rs_value,
    output logic [dual_issue_pkg::DATA_W-1:0]     slave_rt_value
);
    import dual_issue_pkg::*;

    // newest producer first, slave before master within a stage
    function automatic logic [DATA_W-1:0] pick(input logic [REG_ADDR_W-1:0] addr,
                                               input logic [DATA_W-1:0]     rf_val);
        if (addr == '0) begin
            return rf_val;
        end else if (e_slave_wen && e_slave_addr == addr) begin
            return e_slave_data;
        end else if (e_master_wen && e_master_addr == addr) begin
            return e_master_data;
        end else if (wb_slave_wen && wb_slave_addr == addr) begin
            return wb_slave_data;
        end else if (wb_master_wen && wb_master_addr == addr) begin
            return wb_master_data;
        end
        return rf_val;
    endfunction

    always_comb begin
        master_rs_value = pick(master_rs, master_rs_rf);
        master_rt_value = pick(master_rt, master_rt_rf);
        slave_rs_value  = pick(slave_rs, slave_rs_rf);
        slave_rt_value  = pick(slave_rt, slave_rt_rf);
    end

endmodule

// File: hdl/exec_lane.sv
`timescale 1ns/10ps

module exec_lane (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic                                  issue,
    input  dual_issue_pkg::alu_op_t               aluop,
    input  logic                                  alu_sela,
    input  logic                                  alu_selb,
    input  logic [4:0]                            shamt,
    input  logic [dual_issue_pkg::DATA_W-1:0]     imm_value,
    input  logic [dual_issue_pkg::DATA_W-1:0]     rs_value,
    input  logic [dual_issue_pkg::DATA_W-1:0]     rt_value,
    input  logic                                  reg_wen,
    input  logic [dual_issue_pkg::REG_ADDR_W-1:0] reg_waddr,
    output logic                                  e_reg_wen,
    output logic [dual_issue_pkg::REG_ADDR_W-1:0] e_reg_waddr,
    output logic [dual_issue_pkg::DATA_W-1:0]     e_result,
    output logic                                  wb_en,
    output logic [dual_issue_pkg::REG_ADDR_W-1:0] wb_addr,
    output logic [dual_issue_pkg::DATA_W-1:0]     wb_data
);
    import dual_issue_pkg::*;

    alu_op_t           e_aluop;
    logic              e_sela;
    logic              e_selb;
    logic [4:0]        e_shamt;
    logic [DATA_W-1:0] e_imm;
    logic [DATA_W-1:0] e_rs;
    logic [DATA_W-1:0] e_rt;
    logic [DATA_W-1:0] src_a;
    logic [DATA_W-1:0] src_b;

    // execute register, a bubble only clears the write enable
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            e_reg_wen <= 1'b0;
        end else begin
            e_reg_wen <= issue & reg_wen;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            e_reg_waddr <= reg_waddr;
            e_aluop     <= aluop;
            e_sela      <= alu_sela;
            e_selb      <= alu_selb;
            e_shamt     <= shamt;
            e_imm       <= imm_value;
            e_rs        <= rs_value;
            e_rt        <= rt_value;
        end
    end

    // shifts take shamt as operand a
    assign src_a = e_sela ? {27'd0, e_shamt} : e_rs;
    assign src_b = e_selb ? e_imm : e_rt;

    always_comb begin
        case (e_aluop)
            ALU_ADD: e_result = src_a + src_b;
            ALU_SUB: e_result = src_a - src_b;
            ALU_AND: e_result = src_a & src_b;
            ALU_OR:  e_result = src_a | src_b;
            ALU_XOR: e_result = src_a ^ src_b;
            ALU_SLT: e_result = {31'd0, $signed(src_a) < $signed(src_b)};
            ALU_SLL: e_result = src_b << src_a[4:0];
            ALU_SRL: e_result = src_b >> src_a[4:0];
            ALU_LUI: e_result = {src_b[15:0], 16'h0000};
            default: e_result = '0;
        endcase
    end

    // writeback register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_en <= 1'b0;
        end else begin
            wb_en <= e_reg_wen;
        end
    end

    always_ff @(posedge clk) begin
        wb_addr <= e_reg_waddr;
        wb_data <= e_result;
    end

endmodule

// File: hdl/dual_issue_core.sv
`timescale 1ns/10ps

module dual_issue_core (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic                                  inst_data_ok,
    input  logic                                  inst_data_ok1,
    input  logic                                  inst_data_ok2,
    input  logic [dual_issue_pkg::DATA_W-1:0]     inst_rdata1,
    input  logic [dual_issue_pkg::DATA_W-1:0]     inst_rdata2,
    output logic                                  inst_sram_en,
    output logic [dual_issue_pkg::DATA_W-1:0]     fetch_pc,
    output logic                                  master_wb_en,
    output logic [dual_issue_pkg::REG_ADDR_W-1:0] master_wb_addr,
    output logic [dual_issue_pkg::DATA_W-1:0]     master_wb_data,
    output logic                                  slave_wb_en,
    output logic [dual_issue_pkg::REG_ADDR_W-1:0] slave_wb_addr,
    output logic [dual_issue_pkg::DATA_W-1:0]     slave_wb_data
);

    logic push1, push2, full, empty, almost_empty;
    logic master_issue, slave_issue;
    logic [dual_issue_pkg::DATA_W-1:0] head_inst, next_inst;

    // decode outputs per lane
    logic [dual_issue_pkg::REG_ADDR_W-1:0] m_rs, m_rt, m_waddr, s_rs, s_rt, s_waddr;
    dual_issue_pkg::alu_op_t m_aluop, s_aluop;
    logic m_sela, m_selb, m_wen, s_sela, s_selb, s_wen;
    logic [4:0] m_shamt, s_shamt;
    logic [dual_issue_pkg::DATA_W-1:0] m_imm, s_imm;

    // operands before and after forwarding
    logic [dual_issue_pkg::DATA_W-1:0] m_rs_rf, m_rt_rf, s_rs_rf, s_rt_rf;
    logic [dual_issue_pkg::DATA_W-1:0] m_rs_val, m_rt_val, s_rs_val, s_rt_val;

    // execute stage of both lanes
    logic e_m_wen, e_s_wen;
    logic [dual_issue_pkg::REG_ADDR_W-1:0] e_m_addr, e_s_addr;
    logic [dual_issue_pkg::DATA_W-1:0] e_m_res, e_s_res;

    fetch_pc_gen u_fetch_pc_gen (
        .clk(clk), .arst_n(arst_n), .full(full),
        .inst_data_ok(inst_data_ok), .inst_data_ok1(inst_data_ok1),
        .inst_data_ok2(inst_data_ok2), .inst_sram_en(inst_sram_en),
        .fetch_pc(fetch_pc), .push1(push1), .push2(push2)
    );

    inst_fifo u_inst_fifo (
        .clk(clk), .arst_n(arst_n), .push1(push1), .push2(push2),
        .wdata1(inst_rdata1), .wdata2(inst_rdata2),
        .pop1(master_issue), .pop2(slave_issue),
        .head_inst(head_inst), .next_inst(next_inst),
        .empty(empty), .almost_empty(almost_empty), .full(full)
    );

    inst_decoder u_decoder_master (
        .inst(head_inst), .rs(m_rs), .rt(m_rt), .aluop(m_aluop),
        .alu_sela(m_sela), .alu_selb(m_selb), .shamt(m_shamt),
        .imm_value(m_imm), .reg_wen(m_wen), .reg_waddr(m_waddr)
    );

    inst_decoder u_decoder_slave (
        .inst(next_inst), .rs(s_rs), .rt(s_rt), .aluop(s_aluop),
        .alu_sela(s_sela), .alu_selb(s_selb), .shamt(s_shamt),
        .imm_value(s_imm), .reg_wen(s_wen), .reg_waddr(s_waddr)
    );

    regfile u_regfile (
        .clk(clk), .arst_n(arst_n),
        .ra1_a(m_rs), .ra1_b(m_rt), .ra2_a(s_rs), .ra2_b(s_rt),
        .rd1_a(m_rs_rf), .rd1_b(m_rt_rf), .rd2_a(s_rs_rf), .rd2_b(s_rt_rf),
        .wen1(master_wb_en), .wen2(slave_wb_en),
        .wa1(master_wb_addr), .wa2(slave_wb_addr),
        .wd1(master_wb_data), .wd2(slave_wb_data)
    );

    issue_ctrl u_issue_ctrl (
        .empty(empty), .almost_empty(almost_empty),
        .master_reg_wen(m_wen), .master_reg_waddr(m_waddr),
        .slave_rs(s_rs), .slave_rt(s_rt),
        .master_issue(master_issue), .slave_issue(slave_issue)
    );

    forward_unit u_forward_unit (
        .master_rs(m_rs), .master_rt(m_rt), .slave_rs(s_rs), .slave_rt(s_rt),
        .master_rs_rf(m_rs_rf), .master_rt_rf(m_rt_rf),
        .slave_rs_rf(s_rs_rf), .slave_rt_rf(s_rt_rf),
        .e_master_wen(e_m_wen), .e_master_addr(e_m_addr), .e_master_data(e_m_res),
        .e_slave_wen(e_s_wen), .e_slave_addr(e_s_addr), .e_slave_data(e_s_res),
        .wb_master_wen(master_wb_en), .wb_master_addr(master_wb_addr),
        .wb_master_data(master_wb_data),
        .wb_slave_wen(slave_wb_en), .wb_slave_addr(slave_wb_addr),
        .wb_slave_data(slave_wb_data),
        .master_rs_value(m_rs_val), .master_rt_value(m_rt_val),
        .slave_rs_value(s_rs_val), .slave_rt_value(s_rt_val)
    );

    exec_lane u_lane_master (
        .clk(clk), .arst_n(arst_n), .issue(master_issue),
        .aluop(m_aluop), .alu_sela(m_sela), .alu_selb(m_selb), .shamt(m_shamt),
        .imm_value(m_imm), .rs_value(m_rs_val), .rt_value(m_rt_val),
        .reg_wen(m_wen), .reg_waddr(m_waddr),
        .e_reg_wen(e_m_wen), .e_reg_waddr(e_m_addr), .e_result(e_m_res),
        .wb_en(master_wb_en), .wb_addr(master_wb_addr), .wb_data(master_wb_data)
    );

    exec_lane u_lane_slave (
        .clk(clk), .arst_n(arst_n), .issue(slave_issue),
        .aluop(s_aluop), .alu_sela(s_sela), .alu_selb(s_selb), .shamt(s_shamt),
        .imm_value(s_imm), .rs_value(s_rs_val), .rt_value(s_rt_val),
        .reg_wen(s_wen), .reg_waddr(s_waddr),
        .e_reg_wen(e_s_wen), .e_reg_waddr(e_s_addr), .e_result(e_s_res),
        .wb_en(slave_wb_en), .wb_addr(slave_wb_addr), .wb_data(slave_wb_data)
    );

endmodule

// File: verification/dual_issue_core_props.sv
`timescale 1ns/10ps

module dual_issue_core_props (
    input logic                                  clk,
    input logic                                  arst_n,
    input logic                                  inst_sram_en,
    input logic [dual_issue_pkg::DATA_W-1:0]     fetch_pc,
    input logic                                  master_wb_en,
    input logic [dual_issue_pkg::REG_ADDR_W-1:0] master_wb_addr,
    input logic                                  slave_wb_en,
    input logic [dual_issue_pkg::REG_ADDR_W-1:0] slave_wb_addr
);

    // r0 writes are squashed at decode
    master_wb_nonzero: assert property (@(posedge clk) disable iff (!arst_n)
        master_wb_en |-> master_wb_addr != '0)
        else $error("master writeback addressed register zero");

    slave_wb_nonzero: assert property (@(posedge clk) disable iff (!arst_n)
        slave_wb_en |-> slave_wb_addr != '0)
        else $error("slave writeback addressed register zero");

    pc_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        fetch_pc[1:0] == 2'b00)
        else $error("fetch address not word aligned");

    // no request, no address change
    pc_hold: assert property (@(posedge clk) disable iff (!arst_n)
        !inst_sram_en |=> $stable(fetch_pc))
        else $error("fetch address moved while fetch was disabled");

endmodule

bind dual_issue_core dual_issue_core_props u_props (
    .clk(clk),
    .arst_n(arst_n),
    .inst_sram_en(inst_sram_en),
    .fetch_pc(fetch_pc),
    .master_wb_en(master_wb_en),
    .master_wb_addr(master_wb_addr),
    .slave_wb_en(slave_wb_en),
    .slave_wb_addr(slave_wb_addr)
);

// File: verification/dual_issue_core_tb.sv
`timescale 1ns/10ps

module dual_issue_core_tb;

    localparam int N_ROWS       = 31;
    localparam int RESET_CYCLES = 5;
    localparam int DRAIN_CYCLES = 4;
    localparam int TIMEOUT      = 4 * N_ROWS + 20;
    localparam logic [15:0] LFSR_SEED = 16'd14192;
    localparam logic [15:0] LFSR_TAPS = 16'hb400;
    // dest of a row that must not write back
    localparam int NO_WRITE = 0;

    // ISA encodings
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] FN_SLL   = 6'h00;
    localparam logic [5:0] FN_SRL   = 6'h02;
    localparam logic [5:0] FN_ADDU  = 6'h21;
    localparam logic [5:0] FN_SUBU  = 6'h23;
    localparam logic [5:0] FN_AND   = 6'h24;
    localparam logic [5:0] FN_OR    = 6'h25;
    localparam logic [5:0] FN_XOR   = 6'h26;
    localparam logic [5:0] FN_SLT   = 6'h2a;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        inst_data_ok;
    logic        inst_data_ok1;
    logic        inst_data_ok2;
    logic [31:0] inst_rdata1;
    logic [31:0] inst_rdata2;
    logic        inst_sram_en;
    logic [31:0] fetch_pc;
    logic        master_wb_en;
    logic [4:0]  master_wb_addr;
    logic [31:0] master_wb_data;
    logic        slave_wb_en;
    logic [4:0]  slave_wb_addr;
    logic [31:0] slave_wb_data;

    logic [31:0] rows_inst [N_ROWS];
    logic [4:0]  exp_dest_q [$];
    logic [31:0] exp_val_q [$];
    int          rows_added = 0;
    int          exp_writes = 0;
    int          writes_seen = 0;
    int          accepted = 0;
    int          cycles = 0;
    logic [15:0] lfsr;
    logic        prev_en;
    logic [31:0] prev_pc;

    dual_issue_core u_dut (
        .clk(clk), .arst_n(arst_n),
        .inst_data_ok(inst_data_ok), .inst_data_ok1(inst_data_ok1),
        .inst_data_ok2(inst_data_ok2),
        .inst_rdata1(inst_rdata1), .inst_rdata2(inst_rdata2),
        .inst_sram_en(inst_sram_en), .fetch_pc(fetch_pc),
        .master_wb_en(master_wb_en), .master_wb_addr(master_wb_addr),
        .master_wb_data(master_wb_data),
        .slave_wb_en(slave_wb_en), .slave_wb_addr(slave_wb_addr),
        .slave_wb_data(slave_wb_data)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] r_type(input logic [5:0] fn, input int rd, input int rs,
                                           input int rt, input int sh);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
    endfunction

    function automatic logic [31:0] i_type(input logic [5:0] op, input int rt, input int rs,
                                           input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    function automatic logic [31:0] word_at(input int idx);
        return (idx < N_ROWS) ? rows_inst[idx] : 32'h0;
    endfunction

    task automatic add_row(input logic [31:0] inst, input int dest, input logic [31:0] val);
        rows_inst[rows_added] = inst;
        rows_added++;
        if (dest != NO_WRITE) begin
            exp_dest_q.push_back(5'(dest));
            exp_val_q.push_back(val);
            exp_writes++;
        end
    endtask

    task automatic stop_with_failure();
        $display("TEST FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED: %s is 0x%08h, expected 0x%08h", name, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic take_bit(output logic b);
        b = lfsr[0];
        lfsr = lfsr_next(lfsr);
    endtask

    task automatic check_reset_state();
        check_value("master_wb_en", master_wb_en, 0);
        check_value("slave_wb_en", slave_wb_en, 0);
        check_value("fetch_pc", fetch_pc, 0);
        check_value("inst_sram_en", inst_sram_en, 1);
    endtask

    task automatic retire_lane(input string lane, input logic en, input logic [4:0] addr,
                               input logic [31:0] data);
        if (en) begin
            if (exp_val_q.size() == 0) begin
                $display("%s lane wrote back after the last expected write", lane);
                stop_with_failure();
            end else begin
                check_value({lane, "_wb_addr"}, addr, exp_dest_q.pop_front());
                check_value({lane, "_wb_data"}, data, exp_val_q.pop_front());
                writes_seen++;
            end
        end
    endtask

    task automatic check_outputs();
        // master is older within a cycle
        retire_lane("master", master_wb_en, master_wb_addr, master_wb_data);
        retire_lane("slave", slave_wb_en, slave_wb_addr, slave_wb_data);
        if (!prev_en) begin
            check_value("fetch_pc", fetch_pc, prev_pc);
        end
        check_value("fetch_pc", fetch_pc, 32'(accepted * 4));
    endtask

    // memory model, answers in the same cycle
    task automatic drive_memory();
        int   idx;
        logic b1;
        logic b2;
        idx = int'(fetch_pc >> 2);
        prev_pc = fetch_pc;
        prev_en = inst_sram_en;
        b1 = 1'b0;
        b2 = 1'b0;
        if (inst_sram_en && idx < N_ROWS) begin
            take_bit(b1);
            take_bit(b2);
            if (idx == N_ROWS - 1) begin
                b2 = 1'b0;
            end
        end
        // ok2 alone is driven too and must be ignored
        inst_data_ok  = b1 | b2;
        inst_data_ok1 = b1;
        inst_data_ok2 = b2;
        inst_rdata1   = word_at(idx);
        inst_rdata2   = word_at(idx + 1);
        if (b1) begin
            accepted += b2 ? 2 : 1;
        end
    endtask

    initial begin
        arst_n        = 1'b0;
        inst_data_ok  = 1'b0;
        inst_data_ok1 = 1'b0;
        inst_data_ok2 = 1'b0;
        inst_rdata1   = '0;
        inst_rdata2   = '0;
        lfsr          = LFSR_SEED;
        prev_en       = 1'b1;
        prev_pc       = '0;

        add_row(i_type(OP_LUI, 1, 0, 16'h1234), 1, 32'h1234_0000);
        add_row(i_type(OP_ORI, 1, 1, 16'h5678), 1, 32'h1234_5678);
        add_row(i_type(OP_ADDIU, 2, 0, 16'hffff), 2, 32'hffff_ffff);
        add_row(i_type(OP_ORI, 3, 0, 16'h8000), 3, 32'h0000_8000);
        add_row(r_type(FN_ADDU, 4, 1, 2, 0), 4, 32'h1234_5677);
        add_row(r_type(FN_SUBU, 5, 4, 3, 0), 5, 32'h1233_d677);
        add_row(r_type(FN_AND, 6, 5, 1, 0), 6, 32'h1230_5670);
        add_row(r_type(FN_OR, 7, 6, 3, 0), 7, 32'h1230_d670);
        add_row(r_type(FN_XOR, 8, 7, 2, 0), 8, 32'hedcf_298f);
        add_row(r_type(FN_SLT, 9, 2, 3, 0), 9, 32'h0000_0001);
        add_row(r_type(FN_SLT, 10, 3, 2, 0), 10, 32'h0000_0000);
        add_row(r_type(FN_SLL, 11, 0, 3, 4), 11, 32'h0008_0000);
        add_row(r_type(FN_SRL, 12, 0, 2, 28), 12, 32'h0000_000f);
        add_row(r_type(FN_ADDU, 0, 1, 2, 0), NO_WRITE, 32'h0);
        add_row(i_type(OP_LW, 13, 1, 16'h0000), NO_WRITE, 32'h0);
        add_row(r_type(FN_ADDU, 13, 0, 12, 0), 13, 32'h0000_000f);
        // dependent chain, single issue only
        add_row(i_type(OP_ADDIU, 13, 13, 16'h0001), 13, 32'h0000_0010);
        add_row(i_type(OP_ADDIU, 13, 13, 16'h0001), 13, 32'h0000_0011);
        add_row(i_type(OP_ADDIU, 13, 13, 16'h0001), 13, 32'h0000_0012);
        add_row(i_type(OP_ADDIU, 13, 13, 16'h0001), 13, 32'h0000_0013);
        add_row(i_type(OP_ADDIU, 13, 13, 16'h0001), 13, 32'h0000_0014);
        add_row(i_type(OP_ADDIU, 13, 13, 16'h0001), 13, 32'h0000_0015);
        add_row(r_type(FN_ADDU, 14, 13, 13, 0), 14, 32'h0000_002a);
        add_row(r_type(FN_SLL, 15, 0, 14, 1), 15, 32'h0000_0054);
        add_row(r_type(FN_SUBU, 16, 0, 15, 0), 16, 32'hffff_ffac);
        add_row(r_type(FN_SLT, 17, 16, 0, 0), 17, 32'h0000_0001);
        add_row(32'h0000_0000, NO_WRITE, 32'h0);
        add_row(i_type(OP_LUI, 18, 0, 16'hffff), 18, 32'hffff_0000);
        add_row(i_type(OP_ADDIU, 19, 18, 16'h7fff), 19, 32'hffff_7fff);
        add_row(r_type(FN_XOR, 20, 19, 18, 0), 20, 32'h0000_7fff);
        add_row(r_type(FN_OR, 21, 20, 16, 0), 21, 32'hffff_ffff);

        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #2;
            check_reset_state();
        end
        arst_n = 1'b1;
        check_reset_state();
        drive_memory();

        while (writes_seen < exp_writes || accepted < N_ROWS) begin
            @(posedge clk);
            #2;
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("program did not retire in time, %0d of %0d writes after %0d cycles",
                         writes_seen, exp_writes, cycles);
                stop_with_failure();
            end
            check_outputs();
            drive_memory();
        end

        // nothing may retire once the program is done
        repeat (DRAIN_CYCLES) begin
            @(posedge clk);
            #2;
            check_outputs();
            drive_memory();
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: dual_issue_core.f
hdl/dual_issue_pkg.sv
hdl/fetch_pc_gen.sv
hdl/inst_fifo.sv
hdl/inst_decoder.sv
hdl/regfile.sv
hdl/issue_ctrl.sv
hdl/forward_unit.sv
hdl/exec_lane.sv
hdl/dual_issue_core.sv
verification/dual_issue_core_props.sv
verification/dual_issue_core_tb.sv
